/* logic/sd_host_pkg.sv */
package sd_host_pkg;

	// CPU side widths
	typedef logic [11:0] addr_t; // Register offset
	typedef logic [31:0] data_t; // Register value

	localparam int WR_REG_COUNT = 10; // Registers the CPU can write

	typedef logic [WR_REG_COUNT-1:0] wr_enb_t; // One-hot, one bit per writable register

	// Register offsets
	localparam addr_t ADDR_BLK_SIZE      = 12'h004;
	localparam addr_t ADDR_BLK_COUNT     = 12'h006;
	localparam addr_t ADDR_ARGUMENT      = 12'h008;
	localparam addr_t ADDR_XFER_MODE     = 12'h00A;
	localparam addr_t ADDR_COMMAND       = 12'h00E; // Write starts a command
	localparam addr_t ADDR_RESPONSE      = 12'h010;
	localparam addr_t ADDR_BUF_DATA      = 12'h012;
	localparam addr_t ADDR_PRESENT_STATE = 12'h024; // Read only
	localparam addr_t ADDR_HOST_CTRL     = 12'h02A;
	localparam addr_t ADDR_INT_STATUS    = 12'h030; // Read only, read to clear
	localparam addr_t ADDR_ERR_STATUS    = 12'h032;
	localparam addr_t ADDR_ADMA          = 12'h054;

	// Bit of each writable register in wr_enb_t
	localparam int EN_BLK_SIZE   = 0;
	localparam int EN_BLK_COUNT  = 1;
	localparam int EN_ARGUMENT   = 2;
	localparam int EN_XFER_MODE  = 3;
	localparam int EN_COMMAND    = 4;
	localparam int EN_RESPONSE   = 5;
	localparam int EN_BUF_DATA   = 6;
	localparam int EN_HOST_CTRL  = 7;
	localparam int EN_ERR_STATUS = 8;
	localparam int EN_ADMA       = 9;

endpackage

/* logic/sd_status_pkg.sv */
package sd_status_pkg;

	// Present state register (024h)
	localparam int PS_CMD_INHIBIT = 0; // Command line in use

	// Normal interrupt status register (030h)
	localparam int INT_CMD_COMPLETE = 0;

	// Cycles the sequencer spends busy per command
	localparam int CMD_LATENCY = 16;

	// Command sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_BUSY,
		SEQ_DONE
	} seq_state_t;

endpackage

/* logic/sd_reg_port.sv */
`timescale 1ns/1ps

module sd_reg_port (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  logic                 wr_valid,
	input  sd_host_pkg::addr_t   addrs,
	input  sd_host_pkg::data_t   wr_data,
	input  sd_host_pkg::data_t   in_blk_size,
	input  sd_host_pkg::data_t   in_blk_count,
	input  sd_host_pkg::data_t   in_argument,
	input  sd_host_pkg::data_t   in_xfer_mode,
	input  sd_host_pkg::data_t   in_command,
	input  sd_host_pkg::data_t   in_response,
	input  sd_host_pkg::data_t   in_buf_data,
	input  sd_host_pkg::data_t   in_present_state,
	input  sd_host_pkg::data_t   in_host_ctrl,
	input  sd_host_pkg::data_t   in_int_status,
	input  sd_host_pkg::data_t   in_err_status,
	input  sd_host_pkg::data_t   in_adma,
	output sd_host_pkg::data_t   rd_data,
	output logic                 acknowledge,
	output sd_host_pkg::wr_enb_t enb,
	output logic                 int_status_read
);

	sd_host_pkg::wr_enb_t wr_sel; // Decoded enable for the current offset
	sd_host_pkg::data_t   rd_mux; // Selected read value
	logic                 accept; // New request, acknowledged on the next edge

	assign accept = req & ~acknowledge;

	// Read-only and unmapped offsets leave wr_sel at zero
	always_comb begin
		wr_sel = '0;
		rd_mux = '0;
		case (addrs)
			sd_host_pkg::ADDR_BLK_SIZE: begin
				wr_sel[sd_host_pkg::EN_BLK_SIZE] = 1'b1;
				rd_mux = in_blk_size;
			end
			sd_host_pkg::ADDR_BLK_COUNT: begin
				wr_sel[sd_host_pkg::EN_BLK_COUNT] = 1'b1;
				rd_mux = in_blk_count;
			end
			sd_host_pkg::ADDR_ARGUMENT: begin
				wr_sel[sd_host_pkg::EN_ARGUMENT] = 1'b1;
				rd_mux = in_argument;
			end
			sd_host_pkg::ADDR_XFER_MODE: begin
				wr_sel[sd_host_pkg::EN_XFER_MODE] = 1'b1;
				rd_mux = in_xfer_mode;
			end
			sd_host_pkg::ADDR_COMMAND: begin
				wr_sel[sd_host_pkg::EN_COMMAND] = 1'b1;
				rd_mux = in_command;
			end
			sd_host_pkg::ADDR_RESPONSE: begin
				wr_sel[sd_host_pkg::EN_RESPONSE] = 1'b1;
				rd_mux = in_response;
			end
			sd_host_pkg::ADDR_BUF_DATA: begin
				wr_sel[sd_host_pkg::EN_BUF_DATA] = 1'b1;
				rd_mux = in_buf_data;
			end
			sd_host_pkg::ADDR_PRESENT_STATE: rd_mux = in_present_state; // Sequencer owns it
			sd_host_pkg::ADDR_HOST_CTRL: begin
				wr_sel[sd_host_pkg::EN_HOST_CTRL] = 1'b1;
				rd_mux = in_host_ctrl;
			end
			sd_host_pkg::ADDR_INT_STATUS: rd_mux = in_int_status; // Sequencer owns it
			sd_host_pkg::ADDR_ERR_STATUS: begin
				wr_sel[sd_host_pkg::EN_ERR_STATUS] = 1'b1;
				rd_mux = in_err_status;
			end
			sd_host_pkg::ADDR_ADMA: begin
				wr_sel[sd_host_pkg::EN_ADMA] = 1'b1;
				rd_mux = in_adma;
			end
			default: ; // Unmapped, reads zero
		endcase
	end

	// Handshake and one-cycle strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acknowledge     <= 1'b0;
			enb             <= '0;
			int_status_read <= 1'b0;
		end else begin
			acknowledge     <= accept;
			enb             <= (accept && wr_valid) ? wr_sel : '0;
			int_status_read <= accept && !wr_valid && (addrs == sd_host_pkg::ADDR_INT_STATUS);
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !wr_valid)
			rd_data <= rd_mux; // Valid with acknowledge
	end

	a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(enb));

	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		acknowledge |=> !acknowledge);

endmodule

/* logic/sd_reg_file.sv */
`timescale 1ns/1ps

module sd_reg_file (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sd_host_pkg::wr_enb_t enb,
	input  sd_host_pkg::data_t   wr_data,
	output sd_host_pkg::data_t   blk_size,
	output sd_host_pkg::data_t   blk_count,
	output sd_host_pkg::data_t   argument,
	output sd_host_pkg::data_t   xfer_mode,
	output sd_host_pkg::data_t   command,
	output sd_host_pkg::data_t   response,
	output sd_host_pkg::data_t   buf_data,
	output sd_host_pkg::data_t   host_ctrl,
	output sd_host_pkg::data_t   err_status,
	output sd_host_pkg::data_t   adma
);

	// One entry per enable bit
	sd_host_pkg::data_t regs [sd_host_pkg::WR_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sd_host_pkg::WR_REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			for (int i = 0; i < sd_host_pkg::WR_REG_COUNT; i++) begin
				if (enb[i])
					regs[i] <= wr_data;
			end
		end
	end

	assign blk_size   = regs[sd_host_pkg::EN_BLK_SIZE];
	assign blk_count  = regs[sd_host_pkg::EN_BLK_COUNT];
	assign argument   = regs[sd_host_pkg::EN_ARGUMENT];
	assign xfer_mode  = regs[sd_host_pkg::EN_XFER_MODE];
	assign command    = regs[sd_host_pkg::EN_COMMAND];
	assign response   = regs[sd_host_pkg::EN_RESPONSE]; // No real response capture
	assign buf_data   = regs[sd_host_pkg::EN_BUF_DATA];
	assign host_ctrl  = regs[sd_host_pkg::EN_HOST_CTRL];
	assign err_status = regs[sd_host_pkg::EN_ERR_STATUS];
	assign adma       = regs[sd_host_pkg::EN_ADMA];

	// A register moves only on the edge after its own enable
	for (genvar g = 0; g < sd_host_pkg::WR_REG_COUNT; g++) begin : g_chk
		a_write_only: assert property (@(posedge clk) disable iff (!rst_n)
			!enb[g] |=> $stable(regs[g]));
	end

endmodule

/* logic/sd_cmd_sequencer.sv */
`timescale 1ns/1ps

module sd_cmd_sequencer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmd_start,
	input  logic               int_status_read,
	output sd_host_pkg::data_t present_state,
	output sd_host_pkg::data_t int_status
);

	typedef logic [$clog2(sd_status_pkg::CMD_LATENCY)-1:0] lat_cnt_t;

	sd_status_pkg::seq_state_t state;
	lat_cnt_t                  lat_cnt;       // Cycles spent in busy
	logic                      cmd_inhibit;
	logic                      cmd_complete;
	logic                      complete_seen; // Value the port latched for the read
	logic                      complete_clr;

	// Clear only what the CPU actually got back
	assign complete_clr = int_status_read & complete_seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= sd_status_pkg::SEQ_IDLE;
			lat_cnt       <= '0;
			cmd_inhibit   <= 1'b0;
			cmd_complete  <= 1'b0;
			complete_seen <= 1'b0;
		end else begin
			complete_seen <= cmd_complete;
			case (state)
				sd_status_pkg::SEQ_IDLE: begin
					if (cmd_start) begin
						state       <= sd_status_pkg::SEQ_BUSY;
						lat_cnt     <= '0;
						cmd_inhibit <= 1'b1;
					end
				end
				sd_status_pkg::SEQ_BUSY: begin // Further starts ignored here
					if (lat_cnt == lat_cnt_t'(sd_status_pkg::CMD_LATENCY - 1))
						state <= sd_status_pkg::SEQ_DONE;
					else
						lat_cnt <= lat_cnt + 1'b1;
				end
				sd_status_pkg::SEQ_DONE: begin
					cmd_inhibit <= 1'b0;
					state       <= sd_status_pkg::SEQ_IDLE;
				end
				default: state <= sd_status_pkg::SEQ_IDLE;
			endcase

			// A new completion wins over a clear on the same edge
			if (state == sd_status_pkg::SEQ_DONE)
				cmd_complete <= 1'b1;
			else if (complete_clr)
				cmd_complete <= 1'b0;
		end
	end

	always_comb begin
		present_state = '0;
		present_state[sd_status_pkg::PS_CMD_INHIBIT] = cmd_inhibit;
	end

	always_comb begin
		int_status = '0;
		int_status[sd_status_pkg::INT_CMD_COMPLETE] = cmd_complete;
	end

	a_busy_inhibit: assert property (@(posedge clk) disable iff (!rst_n)
		(state == sd_status_pkg::SEQ_BUSY) |-> cmd_inhibit);

endmodule

/* logic/sd_host_regs.sv */
`timescale 1ns/1ps

module sd_host_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req,
	input  logic               wr_valid,
	input  sd_host_pkg::addr_t addrs,
	input  sd_host_pkg::data_t wr_data,
	output sd_host_pkg::data_t rd_data,
	output logic               acknowledge
);

	sd_host_pkg::wr_enb_t enb;
	logic                 int_status_read;

	// Register values back to the read mux
	sd_host_pkg::data_t blk_size;
	sd_host_pkg::data_t blk_count;
	sd_host_pkg::data_t argument;
	sd_host_pkg::data_t xfer_mode;
	sd_host_pkg::data_t command;
	sd_host_pkg::data_t response;
	sd_host_pkg::data_t buf_data;
	sd_host_pkg::data_t present_state;
	sd_host_pkg::data_t host_ctrl;
	sd_host_pkg::data_t int_status;
	sd_host_pkg::data_t err_status;
	sd_host_pkg::data_t adma;

	sd_reg_port port_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.req              (req),
		.wr_valid         (wr_valid),
		.addrs            (addrs),
		.wr_data          (wr_data),
		.in_blk_size      (blk_size),
		.in_blk_count     (blk_count),
		.in_argument      (argument),
		.in_xfer_mode     (xfer_mode),
		.in_command       (command),
		.in_response      (response),
		.in_buf_data      (buf_data),
		.in_present_state (present_state),
		.in_host_ctrl     (host_ctrl),
		.in_int_status    (int_status),
		.in_err_status    (err_status),
		.in_adma          (adma),
		.rd_data          (rd_data),
		.acknowledge      (acknowledge),
		.enb              (enb),
		.int_status_read  (int_status_read)
	);

	sd_reg_file file_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.enb        (enb),
		.wr_data    (wr_data),
		.blk_size   (blk_size),
		.blk_count  (blk_count),
		.argument   (argument),
		.xfer_mode  (xfer_mode),
		.command    (command),
		.response   (response),
		.buf_data   (buf_data),
		.host_ctrl  (host_ctrl),
		.err_status (err_status),
		.adma       (adma)
	);

	sd_cmd_sequencer seq_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd_start       (enb[sd_host_pkg::EN_COMMAND]), // Command register write
		.int_status_read (int_status_read),
		.present_state   (present_state),
		.int_status      (int_status)
	);

endmodule

/* verification/sd_host_regs_checker.sv */
`timescale 1ns/1ps

module sd_host_regs_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req,
	input  logic               acknowledge,
	input  sd_host_pkg::data_t rd_data,
	input  logic               exp_valid,
	input  sd_host_pkg::addr_t exp_addr,
	input  sd_host_pkg::data_t exp_data,
	output int                 mismatch_errors,
	output int                 handshake_errors
);

	int   wait_cycles; // Cycles the current request has waited
	logic acked;       // Current request already acknowledged

	// Sampled on the falling edge, halfway between driving edges
	always @(negedge clk) begin
		if (!rst_n) begin
			wait_cycles      = 0;
			acked            = 1'b0;
			mismatch_errors  = 0;
			handshake_errors = 0;
		end else begin
			if (acknowledge) begin
				if (acked) begin
					handshake_errors++;
					$display("second acknowledge for one request to offset %h", exp_addr);
				end else if (!req) begin
					handshake_errors++;
					$display("acknowledge with no request pending at %0t", $time);
				end else if (wait_cycles != 1) begin
					handshake_errors++;
					$display("acknowledge for offset %h came %0d cycles after req, not 1",
						exp_addr, wait_cycles);
				end
				acked = 1'b1;
				if (exp_valid && rd_data !== exp_data) begin
					mismatch_errors++;
					$display("mismatch rd_data at offset %h: expected %h, got %h",
						exp_addr, exp_data, rd_data);
				end
			end else if (req && !acked) begin
				wait_cycles++;
				if (wait_cycles == 5) begin // Four cycles allowed
					handshake_errors++;
					$display("request to offset %h got no acknowledge within 4 cycles",
						exp_addr);
				end
			end
			if (!req) begin
				wait_cycles = 0;
				acked       = 1'b0;
			end
		end
	end

endmodule

/* verification/sd_host_regs_tb.sv */
`timescale 1ns/1ps

module sd_host_regs_tb;

	localparam string STIM_FILE     = "verification/sd_host_regs_stimulus.txt";
	localparam int    RESET_CYCLES  = 8;
	localparam int    CYCLES_PER_OP = 30; // Watchdog allowance per stimulus line
	localparam int    ACK_WAIT_MAX  = 8;  // Give up on a request after this many cycles

	logic               clk;
	logic               rst_n;
	logic               req;
	logic               wr_valid;
	sd_host_pkg::addr_t addrs;
	sd_host_pkg::data_t wr_data;
	sd_host_pkg::data_t rd_data;
	logic               acknowledge;

	// Expected read value handed to the checker
	logic               exp_valid;
	sd_host_pkg::addr_t exp_addr;
	sd_host_pkg::data_t exp_data;

	int mismatch_errors;
	int handshake_errors;
	int stimulus_errors;
	int watchdog_cycles;
	int wait_sum;

	// Parsed stimulus, one entry per operation
	string              op_kind[$];
	sd_host_pkg::addr_t op_addr[$];
	sd_host_pkg::data_t op_data[$]; // Idle cycle count on a wait line

	always #5 clk = ~clk;

	sd_host_regs dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.wr_valid    (wr_valid),
		.addrs       (addrs),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.acknowledge (acknowledge)
	);

	sd_host_regs_checker checker_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.req              (req),
		.acknowledge      (acknowledge),
		.rd_data          (rd_data),
		.exp_valid        (exp_valid),
		.exp_addr         (exp_addr),
		.exp_data         (exp_data),
		.mismatch_errors  (mismatch_errors),
		.handshake_errors (handshake_errors)
	);

	task automatic load_stimulus();
		int                 fd;
		int                 fields;
		int                 count;
		string              line;
		string              kind;
		sd_host_pkg::addr_t addr;
		sd_host_pkg::data_t data;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stimulus_errors++;
			$display("could not open the stimulus file %s", STIM_FILE);
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line, "%s", kind);
			if (fields < 1)
				continue; // Blank line
			if (kind == "wait") begin
				fields = $sscanf(line, "%s %d", kind, count);
				op_kind.push_back(kind);
				op_addr.push_back('0);
				op_data.push_back(count);
				wait_sum += count;
			end else if (kind == "wr" || kind == "rd") begin
				fields = $sscanf(line, "%s %h %h", kind, addr, data);
				if (fields != 3) begin
					stimulus_errors++;
					$display("stimulus line is missing its offset or data: %s", line);
				end else begin
					op_kind.push_back(kind);
					op_addr.push_back(addr);
					op_data.push_back(data);
				end
			end else begin
				stimulus_errors++;
				$display("unknown operation in the stimulus file: %s", line);
			end
		end
		$fclose(fd);
	endtask

	// One CPU access, held until acknowledge
	task automatic issue_request(input logic is_write, input sd_host_pkg::addr_t addr,
			input sd_host_pkg::data_t data);
		int waited;
		waited = 0;
		@(posedge clk);
		req      <= 1'b1;
		wr_valid <= is_write;
		addrs    <= addr;
		if (is_write)
			wr_data <= data; // Kept after req drops, the register file loads it then
		exp_valid <= !is_write;
		exp_addr  <= addr;
		exp_data  <= data;
		@(negedge clk);
		while (!acknowledge && waited < ACK_WAIT_MAX) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		req       <= 1'b0;
		exp_valid <= 1'b0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	initial begin
		clk             = 1'b0;
		rst_n           = 1'b0;
		req             = 1'b0;
		wr_valid        = 1'b0;
		addrs           = '0;
		wr_data         = '0;
		exp_valid       = 1'b0;
		exp_addr        = '0;
		exp_data        = '0;
		stimulus_errors = 0;
		wait_sum        = 0;
		watchdog_cycles = 0;
		load_stimulus();
		if (stimulus_errors == 0)
			watchdog_cycles = op_kind.size() * CYCLES_PER_OP + wait_sum;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		if (stimulus_errors == 0) begin
			foreach (op_kind[i]) begin
				if (op_kind[i] == "wait")
					idle_cycles(int'(op_data[i]));
				else
					issue_request(op_kind[i] == "wr", op_addr[i], op_data[i]);
			end
		end
		repeat (2) @(posedge clk); // Let the last acknowledge settle
		$display("errors: %0d mismatch, %0d handshake, %0d stimulus",
			mismatch_errors, handshake_errors, stimulus_errors);
		if (mismatch_errors + handshake_errors + stimulus_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog armed once the stimulus length is known
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout after %0d cycles, errors: %0d mismatch, %0d handshake, %0d stimulus",
			watchdog_cycles, mismatch_errors, handshake_errors, stimulus_errors);
		$display("test failed");
		$finish;
	end

endmodule

/* verification/sd_host_regs_stimulus.txt */
# Each line holds a kind (wr, rd or wait), a register offset in hex and a data word in hex
# wr gives the value written, rd the value expected back, wait an idle cycle count in decimal
wr 004 a5a50004
wr 006 5a5a0006
wr 008 12340008
wr 00A 0000000a
wr 00E 0000011e
wr 010 c0de0010
wr 012 beef0012
wr 02A f00d002a
wr 032 0bad0032
wr 054 dead0054
wr 000 ffffffff
wr 00C 1234abcd
wr 024 ffffffff
wr 030 ffffffff
rd 004 a5a50004
rd 006 5a5a0006
rd 008 12340008
rd 00A 0000000a
rd 00E 0000011e
rd 010 c0de0010
rd 012 beef0012
rd 02A f00d002a
rd 032 0bad0032
rd 054 dead0054
rd 024 00000000
rd 030 00000001
rd 030 00000000
rd 000 00000000
rd 00C 00000000
rd 0FE 00000000
wr 00E 0000021e
rd 024 00000001
wr 00E 0000031e
rd 024 00000001
wait 9
rd 024 00000000
rd 030 00000001
rd 030 00000000
wr 00E 0000041e
wait 20
rd 024 00000000
rd 030 00000001
rd 030 00000000
rd 00E 0000041e

/* vlog.f */
logic/sd_host_pkg.sv
logic/sd_status_pkg.sv
logic/sd_reg_port.sv
logic/sd_reg_file.sv
logic/sd_cmd_sequencer.sv
logic/sd_host_regs.sv
verification/sd_host_regs_checker.sv
verification/sd_host_regs_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sd_host_regs_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
